/* list.f */
+incdir+hdl
+incdir+tb
hdl/xlat_pkg.sv
hdl/xlat_csr.sv
hdl/tlb_array.sv
hdl/mmu_port.sv
hdl/xlat_top.sv
tb/tb_xlat.sv

/* Bender.yml */
package:
  name: xlat

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/xlat_pkg.sv
      - hdl/xlat_csr.sv
      - hdl/tlb_array.sv
      - hdl/mmu_port.sv
      - hdl/xlat_top.sv
  - target: test
    include_dirs:
      - hdl
      - tb
    files:
      - tb/tb_xlat.sv

/* tb/xlat_model.svh */
`ifndef XLAT_MODEL_SVH
`define XLAT_MODEL_SVH

xlat_pkg::xlat_cfg_t  ref_cfg;
xlat_pkg::tlb_entry_t ref_tlb [`TLB_ENTRIES];

function automatic void clear_state();
    ref_cfg         = '0;
    ref_cfg.crmd.da = 1'b1;             // reset lands in direct mode
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
        ref_tlb[i] = '0;
    end
endfunction

function automatic void apply_csr_write(xlat_pkg::csr_num_t num, logic [31:0] wdata);
    xlat_pkg::dmw_t dmw;
    // window fields: plv0, plv3, mat, pseg, vseg
    dmw = {wdata[0], wdata[3], wdata[5:4], wdata[27:25], wdata[31:29]};
    case (num)
        xlat_pkg::CSR_CRMD: ref_cfg.crmd = {wdata[1:0], wdata[3], wdata[4],
                                            wdata[6:5], wdata[8:7]};
        xlat_pkg::CSR_ASID: ref_cfg.asid = wdata[`ASID_W-1:0];
        xlat_pkg::CSR_DMW0: ref_cfg.dmw0 = dmw;
        xlat_pkg::CSR_DMW1: ref_cfg.dmw1 = dmw;
    endcase
endfunction

function automatic logic same_page(xlat_pkg::tlb_entry_t te, logic [`VA_W-1:0] va);
    if (te.ps == `PS_4K) begin
        return te.vppn == va[31:13];
    end
    return te.vppn[18:9] == va[31:22];  // 2 MB pair covers va[31:22]
endfunction

function automatic void apply_invalidate(logic [`INVTLB_OP_W-1:0] op,
                                         logic [`ASID_W-1:0] asid, logic [`VA_W-1:0] va);
    logic hit;
    logic asid_eq;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
        asid_eq = ref_tlb[i].asid == asid;
        case (op)
            0, 1:    hit = 1'b1;
            2:       hit = ref_tlb[i].g;
            3:       hit = !ref_tlb[i].g;
            4:       hit = !ref_tlb[i].g && asid_eq;
            5:       hit = !ref_tlb[i].g && asid_eq && same_page(ref_tlb[i], va);
            6:       hit = (ref_tlb[i].g || asid_eq) && same_page(ref_tlb[i], va);
            default: hit = 1'b0;
        endcase
        if (hit) begin
            ref_tlb[i].e = 1'b0;
        end
    end
endfunction

function automatic logic window_hit(xlat_pkg::dmw_t dmw, logic [`VA_W-1:0] va);
    return dmw.vseg == va[31:29] &&
           ((ref_cfg.crmd.plv == 2'd0 && dmw.plv0) || (ref_cfg.crmd.plv == 2'd3 && dmw.plv3));
endfunction

function automatic xlat_pkg::xlat_rsp_t predict_rsp(bit is_fetch, xlat_pkg::xlat_req_t req);
    xlat_pkg::xlat_rsp_t  r;
    xlat_pkg::tlb_entry_t te;
    xlat_pkg::page_t      pg;
    logic [1:0]           mat;
    int                   idx;
    r       = '0;
    r.valid = req.valid;
    mat     = 2'd0;
    idx     = -1;
    if (ref_cfg.crmd.da) begin
        r.pa = req.va;
        mat  = is_fetch ? ref_cfg.crmd.datf : ref_cfg.crmd.datm;
    end else if (window_hit(ref_cfg.dmw0, req.va)) begin
        r.pa = {ref_cfg.dmw0.pseg, req.va[28:0]};
        mat  = ref_cfg.dmw0.mat;
    end else if (window_hit(ref_cfg.dmw1, req.va)) begin
        r.pa = {ref_cfg.dmw1.pseg, req.va[28:0]};
        mat  = ref_cfg.dmw1.mat;
    end else begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            te = ref_tlb[i];
            if (idx < 0 && te.e && (te.g || te.asid == ref_cfg.asid) && same_page(te, req.va)) begin
                idx = i;                // first match from index 0 up
            end
        end
        if (idx < 0) begin
            r.tlbr = 1'b1;
        end else begin
            te = ref_tlb[idx];
            if (te.ps == `PS_4K) begin
                pg = req.va[12] ? te.p1 : te.p0;
            end else begin
                pg = req.va[21] ? te.p1 : te.p0;
            end
            if (!pg.v) begin
                r.pix = 1'b1;
            end else if (ref_cfg.crmd.plv > pg.plv) begin
                r.ppi = 1'b1;
            end else if (!is_fetch && req.store && !pg.d) begin
                r.pme = 1'b1;
            end else begin
                if (te.ps == `PS_4K) begin
                    r.pa = {pg.ppn, req.va[11:0]};
                end else begin
                    r.pa = {pg.ppn[19:9], req.va[20:0]};
                end
                mat = pg.mat;
            end
        end
    end
    r.cacheable = mat == `MAT_CC;       // mat stays 0 on any fault
    return r;
endfunction

`endif

/* tb/tb_xlat.sv */
`timescale 1ns/10ps
`include "xlat_macros.svh"

module tb_xlat;

    localparam int MAX_CYCLES = 4000;

    logic                    clk;
    logic                    reset;
    logic                    csr_wr;
    xlat_pkg::csr_num_t      csr_num;
    logic [31:0]             csr_wdata;
    logic                    tlb_we;
    logic [`TLB_IDX_W-1:0]   tlb_windex;
    xlat_pkg::tlb_entry_t    tlb_wentry;
    logic                    invtlb_valid;
    logic [`INVTLB_OP_W-1:0] invtlb_op;
    logic [`ASID_W-1:0]      invtlb_asid;
    logic [`VA_W-1:0]        invtlb_va;
    xlat_pkg::xlat_req_t     fetch_req;
    xlat_pkg::xlat_req_t     data_req;
    xlat_pkg::xlat_rsp_t     fetch_rsp;
    xlat_pkg::xlat_rsp_t     data_rsp;

    xlat_pkg::xlat_rsp_t     fetch_q[$];     // one prediction in flight per port
    xlat_pkg::xlat_rsp_t     data_q[$];
    logic [`VPPN_W-1:0]      vppn_pool [4];  // few pages so lookups hit often
    int                      cycles = 0;
    int                      checks = 0;
    int                      errors = 0;

    `include "xlat_model.svh"

    xlat_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .csr_wr       (csr_wr),
        .csr_num      (csr_num),
        .csr_wdata    (csr_wdata),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wentry   (tlb_wentry),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .invtlb_asid  (invtlb_asid),
        .invtlb_va    (invtlb_va),
        .fetch_req    (fetch_req),
        .data_req     (data_req),
        .fetch_rsp    (fetch_rsp),
        .data_rsp     (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_port(string name, xlat_pkg::xlat_rsp_t got,
                                xlat_pkg::xlat_rsp_t exp);
        if (exp.valid) begin
            check_value({name, " response"}, got, exp);
        end else begin
            check_value({name, " valid"}, got.valid, 1'b0);
        end
    endtask

    task automatic set_idle();
        csr_wr       = 1'b0;
        csr_num      = xlat_pkg::CSR_CRMD;
        csr_wdata    = '0;
        tlb_we       = 1'b0;
        tlb_windex   = '0;
        tlb_wentry   = '0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        invtlb_asid  = '0;
        invtlb_va    = '0;
        fetch_req    = '0;
        data_req     = '0;
    endtask

    function automatic logic [`VA_W-1:0] rand_va(bit aim_windows);
        logic [`VA_W-1:0] va;
        int               sel;
        int               k;
        va  = $urandom;
        sel = $urandom % 4;
        k   = $urandom % 4;
        if (sel == 1) begin
            va[31:22] = vppn_pool[k][`VPPN_W-1:9];
        end else if (sel > 1) begin
            va[31:13] = vppn_pool[k];
        end
        if (aim_windows && ($urandom % 3) != 0) begin
            va[31:29] = ($urandom % 2) ? ref_cfg.dmw0.vseg : ref_cfg.dmw1.vseg;
        end
        return va;
    endfunction

    function automatic xlat_pkg::tlb_entry_t rand_entry(bit good);
        xlat_pkg::tlb_entry_t te;
        te      = {$urandom, $urandom, $urandom};
        te.e    = good || ($urandom % 8) != 0;
        te.vppn = vppn_pool[$urandom % 4];
        te.ps   = ($urandom % 2) ? `PS_4K : `PS_2M;
        te.asid = 1 + $urandom % 3;
        te.g    = ($urandom % 4) == 0;
        if (good) begin
            te.p0.v   = 1'b1;
            te.p0.d   = 1'b1;
            te.p0.plv = 2'd3;
            te.p1.v   = 1'b1;
            te.p1.d   = 1'b1;
            te.p1.plv = 2'd3;
        end
        return te;
    endfunction

    task automatic random_requests(bit aim_windows);
        fetch_req.valid = ($urandom % 4) != 0;
        fetch_req.va    = rand_va(aim_windows);
        fetch_req.store = $urandom % 2;     // fetch side ignores it
        data_req.valid  = ($urandom % 4) != 0;
        data_req.va     = rand_va(aim_windows);
        data_req.store  = $urandom % 2;
    endtask

    // predict, update the model, cross one rising edge, then compare
    task automatic run_cycle();
        fetch_q.push_back(predict_rsp(1'b1, fetch_req));
        data_q.push_back(predict_rsp(1'b0, data_req));
        if (csr_wr) begin
            apply_csr_write(csr_num, csr_wdata);
        end
        if (invtlb_valid) begin
            apply_invalidate(invtlb_op, invtlb_asid, invtlb_va);
        end
        if (tlb_we) begin
            ref_tlb[tlb_windex] = tlb_wentry;   // write lands after invalidate
        end
        @(negedge clk);
        compare_port("fetch", fetch_rsp, fetch_q.pop_front());
        compare_port("data", data_rsp, data_q.pop_front());
        if (fetch_rsp.valid) begin
            check_value("fetch pme", fetch_rsp.pme, 1'b0);
        end
        set_idle();
    endtask

    task automatic write_csr(xlat_pkg::csr_num_t num, logic [31:0] wdata, bit aim_windows);
        csr_wr    = 1'b1;
        csr_num   = num;
        csr_wdata = wdata;
        random_requests(aim_windows);
        run_cycle();
    endtask

    task automatic refill_tlb(bit good);
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            tlb_we     = 1'b1;
            tlb_windex = i;
            tlb_wentry = rand_entry(good);
            random_requests(1'b0);
            run_cycle();
        end
    endtask

    initial begin
        logic [31:0] wdata;
        void'($urandom(32'ha6a4_8610));
        set_idle();
        reset = 1'b1;
        clear_state();
        for (int i = 0; i < 4; i++) begin
            vppn_pool[i] = $urandom;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // idle after reset, then direct mode requests
        run_cycle();
        repeat (8) begin
            random_requests(1'b0);
            run_cycle();
        end

        // direct mode with random memory types
        repeat (100) begin
            wdata    = $urandom;
            wdata[3] = 1'b1;
            if (($urandom % 4) == 0) begin
                write_csr(xlat_pkg::CSR_CRMD, wdata, 1'b0);
            end else begin
                random_requests(1'b0);
                run_cycle();
            end
        end

        // paged mode, random windows and privilege levels
        for (int n = 0; n < 400; n++) begin
            wdata    = $urandom;
            wdata[3] = 1'b0;
            if (n % 8 == 0) begin
                write_csr(xlat_pkg::CSR_CRMD, wdata, 1'b1);
            end else if (n % 8 == 3) begin
                write_csr(xlat_pkg::CSR_DMW0, $urandom, 1'b1);
            end else if (n % 8 == 5) begin
                write_csr(xlat_pkg::CSR_DMW1, $urandom, 1'b1);
            end else begin
                random_requests(1'b1);
                run_cycle();
            end
        end

        // tlb hits with clean permissions, windows closed
        write_csr(xlat_pkg::CSR_CRMD, 32'h0000_0010, 1'b0);
        write_csr(xlat_pkg::CSR_DMW0, 32'h0, 1'b0);
        write_csr(xlat_pkg::CSR_DMW1, 32'h0, 1'b0);
        write_csr(xlat_pkg::CSR_ASID, 32'h1, 1'b0);
        refill_tlb(1'b1);
        repeat (600) begin
            if (($urandom % 50) == 0) begin
                write_csr(xlat_pkg::CSR_ASID, 1 + $urandom % 3, 1'b0);
            end else begin
                random_requests(1'b0);
                run_cycle();
            end
        end

        // faults: random valid, dirty and privilege bits
        refill_tlb(1'b0);
        repeat (600) begin
            wdata      = $urandom;
            wdata[4:3] = 2'b10;
            if (($urandom % 40) == 0) begin
                write_csr(xlat_pkg::CSR_CRMD, wdata, 1'b0);
            end else begin
                random_requests(1'b0);
                run_cycle();
            end
        end

        // invalidate ops, some with a write on the same cycle
        write_csr(xlat_pkg::CSR_CRMD, 32'h0000_0010, 1'b0);
        for (int r = 0; r < 40; r++) begin
            if (r % 4 == 0) begin
                refill_tlb(1'b1);
            end
            invtlb_valid = 1'b1;
            invtlb_op    = (r == 0) ? 0 : $urandom % 8;
            invtlb_asid  = 1 + $urandom % 3;
            invtlb_va    = rand_va(1'b0);
            if (r == 0 || ($urandom % 4) == 0) begin
                tlb_we     = 1'b1;
                tlb_windex = $urandom % `TLB_ENTRIES;
                tlb_wentry = rand_entry(1'b1);
            end
            random_requests(1'b0);
            run_cycle();
            repeat (15) begin
                random_requests(1'b0);
                run_cycle();
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* hdl/xlat_top.sv */
`timescale 1ns/10ps
`include "xlat_macros.svh"

module xlat_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     csr_wr,
    input  xlat_pkg::csr_num_t       csr_num,
    input  logic [31:0]              csr_wdata,
    input  logic                     tlb_we,
    input  logic [`TLB_IDX_W-1:0]    tlb_windex,
    input  xlat_pkg::tlb_entry_t     tlb_wentry,
    input  logic                     invtlb_valid,
    input  logic [`INVTLB_OP_W-1:0]  invtlb_op,
    input  logic [`ASID_W-1:0]       invtlb_asid,
    input  logic [`VA_W-1:0]         invtlb_va,
    input  xlat_pkg::xlat_req_t      fetch_req,
    input  xlat_pkg::xlat_req_t      data_req,
    output xlat_pkg::xlat_rsp_t      fetch_rsp,
    output xlat_pkg::xlat_rsp_t      data_rsp
);

    xlat_pkg::xlat_cfg_t cfg;
    logic [`VPPN_W:0]    fetch_va_hi;   // tlb port 0
    logic [`VPPN_W:0]    data_va_hi;    // tlb port 1
    xlat_pkg::tlb_hit_t  fetch_hit;
    xlat_pkg::tlb_hit_t  data_hit;

    xlat_csr i_csr (
        .clk       (clk),
        .reset     (reset),
        .csr_wr    (csr_wr),
        .csr_num   (csr_num),
        .csr_wdata (csr_wdata),
        .cfg       (cfg)
    );

    tlb_array i_tlb (
        .clk          (clk),
        .reset        (reset),
        .tlb_we       (tlb_we),
        .tlb_windex   (tlb_windex),
        .tlb_wentry   (tlb_wentry),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .invtlb_asid  (invtlb_asid),
        .invtlb_va    (invtlb_va),
        .cur_asid     (cfg.asid),
        .s0_va_hi     (fetch_va_hi),
        .s0_hit       (fetch_hit),
        .s1_va_hi     (data_va_hi),
        .s1_hit       (data_hit)
    );

    mmu_port #(.is_fetch(1'b1)) i_fetch_mmu (
        .clk       (clk),
        .reset     (reset),
        .req       (fetch_req),
        .cfg       (cfg),
        .tlb_va_hi (fetch_va_hi),
        .tlb_hit   (fetch_hit),
        .rsp       (fetch_rsp)
    );

    mmu_port #(.is_fetch(1'b0)) i_data_mmu (
        .clk       (clk),
        .reset     (reset),
        .req       (data_req),
        .cfg       (cfg),
        .tlb_va_hi (data_va_hi),
        .tlb_hit   (data_hit),
        .rsp       (data_rsp)
    );

endmodule

/* hdl/mmu_port.sv */
`timescale 1ns/10ps
`include "xlat_macros.svh"

module mmu_port #(
    parameter bit is_fetch = 1'b0       // 1 for the instruction side
) (
    input  logic                  clk,
    input  logic                  reset,
    input  xlat_pkg::xlat_req_t   req,
    input  xlat_pkg::xlat_cfg_t   cfg,
    output logic [`VPPN_W:0]      tlb_va_hi,
    input  xlat_pkg::tlb_hit_t    tlb_hit,
    output xlat_pkg::xlat_rsp_t   rsp
);

    xlat_pkg::xlat_rsp_t rsp_d;
    logic [1:0]          da_mat;
    logic                dmw0_hit;
    logic                dmw1_hit;
    logic [`VA_W-1:0]    page_pa;
    logic [1:0]          sel_mat;

    // plv 1 and 2 never get through a window
    function automatic logic dmw_match(input xlat_pkg::dmw_t dmw,
                                       input logic [1:0] plv,
                                       input logic [2:0] vseg);
        return (dmw.vseg == vseg) &&
               ((plv == 2'd0 && dmw.plv0) || (plv == 2'd3 && dmw.plv3));
    endfunction

    assign tlb_va_hi = req.va[`VA_W-1:12];
    assign da_mat    = is_fetch ? cfg.crmd.datf : cfg.crmd.datm;
    assign dmw0_hit  = dmw_match(cfg.dmw0, cfg.crmd.plv, req.va[31:29]);
    assign dmw1_hit  = dmw_match(cfg.dmw1, cfg.crmd.plv, req.va[31:29]);
    assign page_pa   = (tlb_hit.ps == `PS_4K) ?
                       {tlb_hit.page.ppn, req.va[11:0]} :
                       {tlb_hit.page.ppn[`PPN_W-1:9], req.va[20:0]};

    always_comb begin
        rsp_d       = '0;
        rsp_d.valid = req.valid;
        sel_mat     = 2'd0;
        if (cfg.crmd.da) begin
            rsp_d.pa = req.va;
            sel_mat  = da_mat;
        end else if (dmw0_hit) begin
            rsp_d.pa = {cfg.dmw0.pseg, req.va[28:0]};
            sel_mat  = cfg.dmw0.mat;
        end else if (dmw1_hit) begin
            rsp_d.pa = {cfg.dmw1.pseg, req.va[28:0]};
            sel_mat  = cfg.dmw1.mat;
        end else if (!tlb_hit.found) begin
            rsp_d.tlbr = 1'b1;
        end else if (!tlb_hit.page.v) begin
            rsp_d.pix = 1'b1;
        end else if (cfg.crmd.plv > tlb_hit.page.plv) begin
            rsp_d.ppi = 1'b1;
        end else if (!is_fetch && req.store && !tlb_hit.page.d) begin
            rsp_d.pme = 1'b1;              // store to clean page
        end else begin
            rsp_d.pa = page_pa;
            sel_mat  = tlb_hit.page.mat;
        end
        rsp_d.cacheable = (sel_mat == `MAT_CC);  // sel_mat stays 0 on every fault path
    end

    always_ff @(posedge clk) begin
        rsp <= rsp_d;
        if (reset) begin
            rsp.valid <= 1'b0;
        end
    end

endmodule

/* hdl/tlb_array.sv */
`timescale 1ns/10ps
`include "xlat_macros.svh"

module tlb_array (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     tlb_we,
    input  logic [`TLB_IDX_W-1:0]    tlb_windex,
    input  xlat_pkg::tlb_entry_t     tlb_wentry,
    input  logic                     invtlb_valid,
    input  logic [`INVTLB_OP_W-1:0]  invtlb_op,
    input  logic [`ASID_W-1:0]       invtlb_asid,
    input  logic [`VA_W-1:0]         invtlb_va,
    input  logic [`ASID_W-1:0]       cur_asid,
    input  logic [`VPPN_W:0]         s0_va_hi,    // va[31:12]
    output xlat_pkg::tlb_hit_t       s0_hit,
    input  logic [`VPPN_W:0]         s1_va_hi,
    output xlat_pkg::tlb_hit_t       s1_hit
);

    xlat_pkg::tlb_entry_t    ent [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] tlb_e;      // exists bits, the only reset state
    logic [`TLB_ENTRIES-1:0] inv_hit;

    // 2 MB pages only compare the upper 10 bits of the vppn
    function automatic logic page_match(input xlat_pkg::tlb_entry_t te,
                                        input logic [`VPPN_W-1:0] vppn);
        if (te.ps == `PS_4K) begin
            return te.vppn == vppn;
        end
        return te.vppn[`VPPN_W-1:9] == vppn[`VPPN_W-1:9];
    endfunction

    function automatic xlat_pkg::tlb_hit_t lookup(input logic [`VPPN_W:0] va_hi);
        xlat_pkg::tlb_hit_t hit;
        logic               odd;
        hit = '0;
        // walk down so the lowest index is the one left standing
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (tlb_e[i] && (ent[i].g || ent[i].asid == cur_asid) &&
                page_match(ent[i], va_hi[`VPPN_W:1])) begin
                odd       = (ent[i].ps == `PS_4K) ? va_hi[0] : va_hi[9];  // va[12] or va[21]
                hit.found = 1'b1;
                hit.ps    = ent[i].ps;
                hit.page  = odd ? ent[i].p1 : ent[i].p0;
            end
        end
        return hit;
    endfunction

    // lookup also reads the entries and the current asid
    always_comb begin
        s0_hit = lookup(s0_va_hi);
        s1_hit = lookup(s1_va_hi);
    end

    // per-entry invalidate select
    always_comb begin
        logic asid_eq;
        logic va_eq;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            asid_eq = ent[i].asid == invtlb_asid;
            va_eq   = page_match(ent[i], invtlb_va[`VA_W-1:13]);
            case (invtlb_op)
                5'd0, 5'd1: inv_hit[i] = 1'b1;
                5'd2:       inv_hit[i] = ent[i].g;
                5'd3:       inv_hit[i] = !ent[i].g;
                5'd4:       inv_hit[i] = !ent[i].g && asid_eq;
                5'd5:       inv_hit[i] = !ent[i].g && asid_eq && va_eq;
                5'd6:       inv_hit[i] = (ent[i].g || asid_eq) && va_eq;
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tlb_e <= '0;
        end else begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                if (tlb_we && tlb_windex == i[`TLB_IDX_W-1:0]) begin
                    tlb_e[i] <= tlb_wentry.e;   // write beats invalidate
                end else if (invtlb_valid && inv_hit[i]) begin
                    tlb_e[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            ent[tlb_windex] <= tlb_wentry;
        end
    end

endmodule

/* hdl/xlat_csr.sv */
`timescale 1ns/10ps
`include "xlat_macros.svh"

module xlat_csr (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 csr_wr,
    input  xlat_pkg::csr_num_t   csr_num,
    input  logic [31:0]          csr_wdata,
    output xlat_pkg::xlat_cfg_t  cfg
);

    // window register layout, shared by dmw0 and dmw1
    function automatic xlat_pkg::dmw_t to_dmw(input logic [31:0] wdata);
        xlat_pkg::dmw_t dmw;
        dmw.plv0 = wdata[0];
        dmw.plv3 = wdata[3];
        dmw.mat  = wdata[5:4];
        dmw.pseg = wdata[27:25];
        dmw.vseg = wdata[31:29];
        return dmw;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.crmd.plv  <= 2'd0;
            cfg.crmd.da   <= 1'b1;          // come up in direct mode
            cfg.crmd.pg   <= 1'b0;
            cfg.crmd.datf <= 2'd0;
            cfg.crmd.datm <= 2'd0;
            cfg.asid      <= '0;
            cfg.dmw0      <= '0;
            cfg.dmw1      <= '0;
        end else if (csr_wr) begin
            case (csr_num)
                xlat_pkg::CSR_CRMD: begin
                    cfg.crmd.plv  <= csr_wdata[1:0];
                    cfg.crmd.da   <= csr_wdata[3];
                    cfg.crmd.pg   <= csr_wdata[4];
                    cfg.crmd.datf <= csr_wdata[6:5];
                    cfg.crmd.datm <= csr_wdata[8:7];
                end
                xlat_pkg::CSR_ASID: begin
                    cfg.asid <= csr_wdata[`ASID_W-1:0];
                end
                xlat_pkg::CSR_DMW0: begin
                    cfg.dmw0 <= to_dmw(csr_wdata);
                end
                xlat_pkg::CSR_DMW1: begin
                    cfg.dmw1 <= to_dmw(csr_wdata);
                end
                default: begin
                    cfg <= cfg;             // unknown number, ignored
                end
            endcase
        end
    end

endmodule

/* hdl/xlat_pkg.sv */
`include "xlat_macros.svh"

package xlat_pkg;

    typedef struct packed {
        logic [1:0] plv;        // current privilege level
        logic       da;         // direct address mode
        logic       pg;         // paging enable
        logic [1:0] datf;       // fetch mat in direct mode
        logic [1:0] datm;       // load/store mat in direct mode
    } crmd_t;

    typedef struct packed {
        logic       plv0;       // window usable at plv 0
        logic       plv3;       // window usable at plv 3
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_t;

    typedef struct packed {
        crmd_t              crmd;
        logic [`ASID_W-1:0] asid;
        dmw_t               dmw0;
        dmw_t               dmw1;
    } xlat_cfg_t;

    // architectural csr numbers
    typedef enum logic [13:0] {
        CSR_CRMD = 14'h000,
        CSR_ASID = 14'h018,
        CSR_DMW0 = 14'h180,
        CSR_DMW1 = 14'h181
    } csr_num_t;

    typedef struct packed {
        logic [`PPN_W-1:0] ppn;
        logic [1:0]        plv;
        logic [1:0]        mat;
        logic              d;
        logic              v;
    } page_t;

    typedef struct packed {
        logic               e;
        logic [`VPPN_W-1:0] vppn;
        logic [5:0]         ps;
        logic [`ASID_W-1:0] asid;
        logic               g;
        page_t              p0;  // even page
        page_t              p1;  // odd page
    } tlb_entry_t;

    typedef struct packed {
        logic       found;
        logic [5:0] ps;
        page_t      page;        // half picked by the va
    } tlb_hit_t;

    typedef struct packed {
        logic             valid;
        logic [`VA_W-1:0] va;
        logic             store;
    } xlat_req_t;

    typedef struct packed {
        logic             valid;
        logic [`VA_W-1:0] pa;
        logic             cacheable;
        logic             tlbr;
        logic             pix;
        logic             ppi;
        logic             pme;
    } xlat_rsp_t;

endpackage

/* hdl/xlat_macros.svh */
`ifndef XLAT_MACROS_SVH
`define XLAT_MACROS_SVH

// address and page number widths
`define VA_W        32
`define VPPN_W      19
`define PPN_W       20
`define ASID_W      10

// tlb geometry
`define TLB_ENTRIES 16
`define TLB_IDX_W   4

// legal page size codes, log2 of the page size
`define PS_4K       12
`define PS_2M       21

// memory type code for coherent cached access
`define MAT_CC      1

`define INVTLB_OP_W 5

`endif
